// ==== mul_params.svh ====
`ifndef MUL_PARAMS_SVH
`define MUL_PARAMS_SVH

// widths of the rv32 m-extension multiplier
// these are set by the instruction set
// the half split only works for these values

// operand width, one register of rv32
`define MUL_XLEN 32

// half of an operand, the width of one multiplier factor
`define MUL_HALF 16

// cross products of two halved operands
// ordered ll, lh, hl, hh everywhere
`define MUL_NUM_PP 4

// full product is 2*MUL_XLEN wide
// partial product is 2*MUL_HALF wide

`endif

// ==== mul_pkg.sv ====
`include "mul_params.svh"

package mul_pkg;

    // multiply operations
    // encoding follows the funct3 order of the m extension
    typedef enum logic [1:0] {
        op_mul    = 2'd0,
        op_mulh   = 2'd1,
        op_mulhsu = 2'd2,
        op_mulhu  = 2'd3
    } mul_op_e;

    // one partial-product job
    // both factors are unsigned halves
    typedef struct packed {
        logic [`MUL_HALF-1:0] a;
        logic [`MUL_HALF-1:0] b;
    } mul_pp_in_t;

    // side-band control carried beside the products
    typedef struct packed {
        // job present in this stage
        logic                 valid;
        // selects lo or hi word at the end
        mul_op_e              op;
        // sign correction for the hi word
        logic [`MUL_XLEN-1:0] comp;
    } mul_ctrl_t;

    // two halves of the product word
    // hi first, so it lands on the upper bits
    typedef struct packed {
        logic [`MUL_XLEN-1:0] hi;
        logic [`MUL_XLEN-1:0] lo;
    } mul_product_half_t;

    // product written as one 64-bit sum
    // and read back as hi or lo for the result
    typedef union packed {
        logic [2*`MUL_XLEN-1:0] full;
        mul_product_half_t      half;
    } mul_product_u;

endpackage

// ==== mul_operand_split.sv ====
`timescale 1ns/1ps

`include "mul_params.svh"

module mul_operand_split (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 in_valid,
    input  mul_pkg::mul_op_e     op,
    input  logic [`MUL_XLEN-1:0] src1,
    input  logic [`MUL_XLEN-1:0] src2,
    output mul_pkg::mul_pp_in_t  pp_in [`MUL_NUM_PP],
    output mul_pkg::mul_ctrl_t   ctrl_s1
);

    // operand signedness
    logic                 src1_signed;
    logic                 src2_signed;

    // halves of each operand
    logic [`MUL_HALF-1:0] src1_lo;
    logic [`MUL_HALF-1:0] src1_hi;
    logic [`MUL_HALF-1:0] src2_lo;
    logic [`MUL_HALF-1:0] src2_hi;

    // the two correction terms and their sum
    logic [`MUL_XLEN-1:0] comp_from_src1;
    logic [`MUL_XLEN-1:0] comp_from_src2;
    logic [`MUL_XLEN-1:0] comp;

    // mulh signs both, mulhsu only src1
    // mul and mulhu stay unsigned, the low word does not care
    assign src1_signed = (op == mul_pkg::op_mulh) || (op == mul_pkg::op_mulhsu);
    assign src2_signed = (op == mul_pkg::op_mulh);

    assign src1_lo = src1[`MUL_HALF-1:0];
    assign src1_hi = src1[`MUL_XLEN-1:`MUL_HALF];
    assign src2_lo = src2[`MUL_HALF-1:0];
    assign src2_hi = src2[`MUL_XLEN-1:`MUL_HALF];

    // four cross products
    // first letter is the src1 half, second the src2 half
    always_comb begin
        // ll
        pp_in[0].a = src1_lo;
        pp_in[0].b = src2_lo;
        // lh
        pp_in[1].a = src1_lo;
        pp_in[1].b = src2_hi;
        // hl
        pp_in[2].a = src1_hi;
        pp_in[2].b = src2_lo;
        // hh
        pp_in[3].a = src1_hi;
        pp_in[3].b = src2_hi;
    end

    // a negative src1 read as unsigned is too big by 2^32
    // so the product is too big by src2 << 32
    assign comp_from_src1 = (src1_signed && src1[`MUL_XLEN-1]) ? src2 : '0;

    // same story mirrored for src2
    assign comp_from_src2 = (src2_signed && src2[`MUL_XLEN-1]) ? src1 : '0;

    // wraps modulo 2^32, only the hi word is touched
    assign comp = comp_from_src1 + comp_from_src2;

    // stage 1 control, aligned with the partial-product registers
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ctrl_s1.valid <= 1'b0;
            ctrl_s1.op    <= mul_pkg::op_mul;
            ctrl_s1.comp  <= '0;
        end else begin
            ctrl_s1.valid <= in_valid;
            ctrl_s1.op    <= op;
            ctrl_s1.comp  <= comp;
        end
    end

endmodule

// ==== mul_partial_product.sv ====
`timescale 1ns/1ps

`include "mul_params.svh"

module mul_partial_product (
    input  logic                   clk,
    input  logic                   rstn,
    input  mul_pkg::mul_pp_in_t    pp_in,
    output logic [2*`MUL_HALF-1:0] pp
);

    // unsigned 16x16 product, never overflows 32 bits
    logic [2*`MUL_HALF-1:0] product;

    // widen both factors first so the multiply is done at full width
    assign product = {{`MUL_HALF{1'b0}}, pp_in.a} * {{`MUL_HALF{1'b0}}, pp_in.b};

    // stage 1 register for this share of the product
    // runs every cycle, the valid bit travels in ctrl_s1
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pp <= '0;
        end else begin
            pp <= product;
        end
    end

endmodule

// ==== mul_accumulate.sv ====
`timescale 1ns/1ps

`include "mul_params.svh"

module mul_accumulate (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic [2*`MUL_HALF-1:0] pp_s1 [`MUL_NUM_PP],
    input  mul_pkg::mul_ctrl_t     ctrl_s1,
    output logic                   res_valid,
    output logic [`MUL_XLEN-1:0]   res
);

    // partial products widened to the product width
    logic [2*`MUL_XLEN-1:0] ll_ext;
    logic [2*`MUL_XLEN-1:0] lh_ext;
    logic [2*`MUL_XLEN-1:0] hl_ext;
    logic [2*`MUL_XLEN-1:0] hh_ext;

    // aligned and summed, before the sign correction
    logic [2*`MUL_XLEN-1:0] raw_sum;

    // corrected product
    mul_pkg::mul_product_u  product;

    // word picked for the result
    logic [`MUL_XLEN-1:0]   res_next;

    // zero extension, all four are unsigned
    assign ll_ext = {{`MUL_XLEN{1'b0}}, pp_s1[0]};
    assign lh_ext = {{`MUL_XLEN{1'b0}}, pp_s1[1]};
    assign hl_ext = {{`MUL_XLEN{1'b0}}, pp_s1[2]};
    assign hh_ext = {{`MUL_XLEN{1'b0}}, pp_s1[3]};

    // ll at 0, the two middle terms at 16, hh at 32
    // sum wraps modulo 2^64
    assign raw_sum = ll_ext
                   + (lh_ext << `MUL_HALF)
                   + (hl_ext << `MUL_HALF)
                   + (hh_ext << `MUL_XLEN);

    // write as one word, fix the hi half
    // subtracting comp from hi equals subtracting comp << 32 mod 2^64
    always_comb begin
        product.full    = raw_sum;
        product.half.hi = product.half.hi - ctrl_s1.comp;
    end

    // low word for mul
    // high word for mulh, mulhsu and mulhu
    always_comb begin
        if (ctrl_s1.op == mul_pkg::op_mul) begin
            res_next = product.half.lo;
        end else begin
            res_next = product.half.hi;
        end
    end

    // stage 2 output strobe
    // one cycle after ctrl_s1, two after the input
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= ctrl_s1.valid;
        end
    end

    // result only moves on a real job
    // holds its value through bubbles
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            res <= '0;
        end else if (ctrl_s1.valid) begin
            res <= res_next;
        end
    end

endmodule

// ==== mul_unit.sv ====
`timescale 1ns/1ps

`include "mul_params.svh"

module mul_unit (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 in_valid,
    input  mul_pkg::mul_op_e     op,
    input  logic [`MUL_XLEN-1:0] src1,
    input  logic [`MUL_XLEN-1:0] src2,
    output logic                 res_valid,
    output logic [`MUL_XLEN-1:0] res
);

    // two-stage pipeline
    // stage 1 forms the four partial products and the control word
    // stage 2 sums them and selects the result word
    // one new job per cycle, no stall, no back-pressure

    // partial-product jobs, combinational from the splitter
    mul_pkg::mul_pp_in_t    pp_in [`MUL_NUM_PP];

    // stage 1 registered products, ll lh hl hh
    logic [2*`MUL_HALF-1:0] pp_s1 [`MUL_NUM_PP];

    // stage 1 registered control
    mul_pkg::mul_ctrl_t     ctrl_s1;

    // decode, split, compensation
    mul_operand_split u_split (
        .clk      (clk),
        .rstn     (rstn),
        .in_valid (in_valid),
        .op       (op),
        .src1     (src1),
        .src2     (src2),
        .pp_in    (pp_in),
        .ctrl_s1  (ctrl_s1)
    );

    // one multiplier per cross product
    for (genvar k = 0; k < `MUL_NUM_PP; k++) begin : g_pp
        mul_partial_product u_pp (
            .clk   (clk),
            .rstn  (rstn),
            .pp_in (pp_in[k]),
            .pp    (pp_s1[k])
        );
    end

    // align, sum, correct, select
    mul_accumulate u_acc (
        .clk       (clk),
        .rstn      (rstn),
        .pp_s1     (pp_s1),
        .ctrl_s1   (ctrl_s1),
        .res_valid (res_valid),
        .res       (res)
    );

endmodule

// ==== mul_unit_assertions.sv ====
`timescale 1ns/1ps

`include "mul_params.svh"

module mul_unit_assertions (
    input logic                 clk,
    input logic                 rstn,
    input logic                 in_valid,
    input logic                 res_valid,
    input logic [`MUL_XLEN-1:0] res
);

    // output strobe trails the input strobe by two edges
    property p_latency;
        @(posedge clk) disable iff (!rstn)
            res_valid == $past(in_valid, 2);
    endproperty

    // reset clears the output strobe
    property p_reset_quiet;
        @(posedge clk)
            !rstn |=> !res_valid;
    endproperty

    // strobe itself never floats
    property p_valid_known;
        @(posedge clk) disable iff (!rstn)
            !$isunknown(res_valid);
    endproperty

    // a presented result is fully defined
    property p_res_known;
        @(posedge clk) disable iff (!rstn)
            res_valid |-> !$isunknown(res);
    endproperty

    a_latency: assert property (p_latency)
        else $error("res_valid does not follow in_valid by two cycles");

    a_reset_quiet: assert property (p_reset_quiet)
        else $error("res_valid high while in reset");

    a_valid_known: assert property (p_valid_known)
        else $error("res_valid has unknown value");

    a_res_known: assert property (p_res_known)
        else $error("res has unknown bits while res_valid is high");

endmodule

// ==== tb_mul_unit.sv ====
`timescale 1ns/1ps

`include "mul_params.svh"

module tb_mul_unit;

    // one expected output slot, one per clock
    typedef struct packed {
        logic                 valid;
        logic [`MUL_XLEN-1:0] res;
    } expect_t;

    // generous bound for any wait on the pipeline
    localparam int TIMEOUT_CYCLES = 20;

    logic                 clk;
    logic                 rstn;
    logic                 in_valid;
    mul_pkg::mul_op_e     op;
    logic [`MUL_XLEN-1:0] src1;
    logic [`MUL_XLEN-1:0] src2;
    logic                 res_valid;
    logic [`MUL_XLEN-1:0] res;

    // expectations in issue order, head is due at the next falling edge
    expect_t              pending [$];
    logic [31:0]          lfsr;
    int                   n_checked;

    mul_unit DUT (
        .clk       (clk),
        .rstn      (rstn),
        .in_valid  (in_valid),
        .op        (op),
        .src1      (src1),
        .src2      (src2),
        .res_valid (res_valid),
        .res       (res)
    );

    // pipeline timing checks
    bind mul_unit mul_unit_assertions u_assertions (
        .clk       (clk),
        .rstn      (rstn),
        .in_valid  (in_valid),
        .res_valid (res_valid),
        .res       (res)
    );

    // 40 ns period
    always #20 clk = ~clk;

    task automatic fail_now();
        $display("Test failed");
        $fatal(1, "stopped at first error");
    endtask

    // galois form, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] next_lfsr(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // one lfsr step per bit, msb first
    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = next_lfsr(lfsr);
        end
    endtask

    // reference product on sign or zero extended operands
    function automatic logic [31:0] model_result(input mul_pkg::mul_op_e f_op,
                                                 input logic [31:0] a,
                                                 input logic [31:0] b);
        logic        a_signed;
        logic        b_signed;
        logic [63:0] wa;
        logic [63:0] wb;
        logic [63:0] prod;
        a_signed = (f_op == mul_pkg::op_mulh) || (f_op == mul_pkg::op_mulhsu);
        b_signed = (f_op == mul_pkg::op_mulh);
        wa = a_signed ? {{32{a[31]}}, a} : {32'd0, a};
        wb = b_signed ? {{32{b[31]}}, b} : {32'd0, b};
        // 64-bit wrap gives the right two's complement product
        prod = wa * wb;
        if (f_op == mul_pkg::op_mul) begin
            return prod[31:0];
        end
        return prod[63:32];
    endfunction

    // any real job still inside the pipeline
    function automatic bit job_in_flight();
        foreach (pending[i]) begin
            if (pending[i].valid) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // check the slot due now, then drive the next input
    task automatic drive_cycle(input logic v, input mul_pkg::mul_op_e d_op,
                               input logic [31:0] a, input logic [31:0] b);
        expect_t slot;
        expect_t slot_in;
        @(negedge clk);
        // outputs settled since the last rising edge
        slot = pending.pop_front();
        assert (res_valid === slot.valid) else begin
            $display("** Error at %0t ns: res_valid expected %0b, got %0b",
                     $time, slot.valid, res_valid);
            fail_now();
        end
        if (slot.valid) begin
            assert (res === slot.res) else begin
                $display("** Error at %0t ns: res expected 0x%08h, got 0x%08h",
                         $time, slot.res, res);
                fail_now();
            end
            n_checked++;
        end
        in_valid = v;
        op       = d_op;
        src1     = a;
        src2     = b;
        slot_in.valid = v;
        slot_in.res   = v ? model_result(d_op, a, b) : '0;
        pending.push_back(slot_in);
    endtask

    // idle cycles until every job has come out
    task automatic drain();
        int cycles;
        cycles = 0;
        while (job_in_flight()) begin
            drive_cycle(1'b0, mul_pkg::op_mul, '0, '0);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                $display("timeout: pipeline did not empty after the last operation");
                fail_now();
            end
        end
    endtask

    // single job, the slot check pins it to two edges
    task automatic issue_op(input mul_pkg::mul_op_e d_op,
                            input logic [31:0] a, input logic [31:0] b);
        drive_cycle(1'b1, d_op, a, b);
        drain();
    endtask

    task automatic reset_behavior();
        expect_t idle_slot;
        idle_slot = '0;
        rstn = 1'b0;
        repeat (2) begin
            @(negedge clk);
            assert (res_valid === 1'b0) else begin
                $display("** Error at %0t ns: res_valid expected 0, got %0b",
                         $time, res_valid);
                fail_now();
            end
        end
        rstn = 1'b1;
        // stages come out of reset empty
        pending.push_back(idle_slot);
        pending.push_back(idle_slot);
        repeat (4) drive_cycle(1'b0, mul_pkg::op_mul, '0, '0);
    endtask

    task automatic unsigned_corners();
        logic [31:0] corner [4];
        corner = '{32'h0000_0000, 32'h0000_0001, 32'hffff_ffff, 32'h0000_ffff};
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
                issue_op(mul_pkg::op_mul, corner[i], corner[j]);
                issue_op(mul_pkg::op_mulhu, corner[i], corner[j]);
            end
        end
    endtask

    // both compensation terms, alone and together
    task automatic signed_corners();
        logic [31:0] a_list [8];
        logic [31:0] b_list [8];
        a_list = '{32'h8000_0000, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff,
                   32'hffff_ffff, 32'h0000_0001, 32'hffff_fffe, 32'h1234_5678};
        b_list = '{32'h8000_0000, 32'hffff_ffff, 32'h7fff_ffff, 32'h8000_0000,
                   32'h0000_0001, 32'hffff_ffff, 32'h0000_0003, 32'hedcb_a988};
        for (int i = 0; i < 8; i++) begin
            issue_op(mul_pkg::op_mulh, a_list[i], b_list[i]);
        end
    endtask

    // src2 top bit set must not pull a correction
    task automatic mixed_sign_mulhsu();
        logic [31:0] a_list [6];
        logic [31:0] b_list [6];
        a_list = '{32'h8000_0000, 32'hffff_ffff, 32'hffff_fff0,
                   32'h7fff_ffff, 32'h0000_0002, 32'h0000_ffff};
        b_list = '{32'hffff_ffff, 32'hffff_ffff, 32'h8000_0001,
                   32'hffff_ffff, 32'h8000_0000, 32'hfedc_ba98};
        for (int i = 0; i < 6; i++) begin
            issue_op(mul_pkg::op_mulhsu, a_list[i], b_list[i]);
        end
    endtask

    // one job per cycle, order and latency checked per slot
    task automatic random_stream();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] o;
        for (int i = 0; i < 200; i++) begin
            take_bits(32, a);
            take_bits(32, b);
            take_bits(2, o);
            drive_cycle(1'b1, mul_pkg::mul_op_e'(o[1:0]), a, b);
        end
        drain();
    endtask

    // junk operands ride along in the gaps
    task automatic random_bubbles();
        logic [31:0] v;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] o;
        for (int i = 0; i < 200; i++) begin
            take_bits(1, v);
            take_bits(32, a);
            take_bits(32, b);
            take_bits(2, o);
            drive_cycle(v[0], mul_pkg::mul_op_e'(o[1:0]), a, b);
        end
        drain();
    endtask

    initial begin
        clk       = 1'b0;
        rstn      = 1'b0;
        in_valid  = 1'b0;
        op        = mul_pkg::op_mul;
        src1      = '0;
        src2      = '0;
        lfsr      = 32'h6c80;
        n_checked = 0;

        reset_behavior();
        unsigned_corners();
        signed_corners();
        mixed_sign_mulhsu();
        random_stream();
        random_bubbles();

        if (n_checked > 0) begin
            $display("Test passed");
            $finish;
        end else begin
            $display("no results were checked");
            $display("Test failed");
            $fatal(1, "empty run");
        end
    end

endmodule

// ==== project.f ====
+incdir+.
mul_pkg.sv
mul_operand_split.sv
mul_partial_product.sv
mul_accumulate.sv
mul_unit.sv
mul_unit_assertions.sv
tb_mul_unit.sv

// ==== Makefile ====
# Verilator build and run for the pipelined multiplier

VERILATOR ?= verilator
TOP       ?= tb_mul_unit
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Test passed
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

SOURCES   := $(wildcard *.sv) $(wildcard *.svh)
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check $(LOG) for the pass line"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   this list"
	@echo "overridable: VERILATOR TOP FILELIST OBJ_DIR LOG PASS_MSG JOBS VFLAGS"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation PASS"; \
	else \
		echo "simulation FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
